/* cc_queue.f */
rtl/cc_queue_pkg.sv
rtl/cc_rate_ctrl.sv
rtl/req_fifo.sv
rtl/req_pacer.sv
rtl/cc_queue_top.sv
tb/tb_cc_queue.sv

/* Makefile */
# Verilator build of the congestion-controlled request queue testbench

VERILATOR ?= verilator
TOP       ?= tb_cc_queue
FILELIST  ?= cc_queue.f
OBJ_DIR   ?= obj_dir
SIM_BIN   ?= $(OBJ_DIR)/V$(TOP)
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= === PASS ===

SRCS := $(wildcard rtl/*.sv tb/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/tb_cc_queue.sv */
module tb_cc_queue;

    import cc_queue_pkg::*;

    localparam int BURST_CYC  = 100;
    localparam int WARM_CYC   = 500;
    localparam int MARK_CYC   = 2000;
    localparam int QUIET_CYC  = 3000;
    localparam int REMARK_CYC = 1000;
    localparam int IDLE_CYC   = 2000;
    localparam int PHASE_CYC  = BURST_CYC + WARM_CYC + MARK_CYC + QUIET_CYC
                                + REMARK_CYC + IDLE_CYC;
    localparam int WDOG_CYC   = PHASE_CYC + 4 + QDEPTH * int'(GAP_INIT);

    logic             aclk, aresetn, req_push, ack_valid, ack_ecn, out_valid, overflow;
    logic [REQ_W-1:0] req_data, out_data;
    logic [GAP_W-1:0] cur_gap;

    // rate controller model
    logic [GAP_W-1:0]  m_timer, m_target, m_cur, m_last_dec, m_last_mark, m_tcnt, m_acnt;
    logic [STG_W-1:0]  m_tstg, m_astg;
    logic [FIDX_W-1:0] m_fidx;
    logic              m_event;
    // fifo and pacer model
    logic [REQ_W-1:0]  m_words[$];
    logic [GAP_W-1:0]  m_pop_gaps[$];
    logic [REQ_W-1:0]  m_rd_data, m_out_data;
    logic [GAP_W-1:0]  m_ptimer;
    logic              m_pop_q, m_out_valid, m_overflow;

    logic [31:0] lfsr;
    int          cyc, last_ov, delivered;

    cc_queue_top dut0 (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .req_push  (req_push),
        .req_data  (req_data),
        .ack_valid (ack_valid),
        .ack_ecn   (ack_ecn),
        .out_valid (out_valid),
        .out_data  (out_data),
        .cur_gap   (cur_gap),
        .overflow  (overflow)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    // ====================
    // helpers
    // ====================

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [63:0] v);
        int k;
        v = '0;
        for (k = 0; k < n; k++) begin
            v = {v[62:0], lfsr[0]};
            lfsr = galois_step(lfsr);
        end
    endtask

    function automatic logic [STG_W-1:0] stage_up(input logic [STG_W-1:0] s);
        return (s < STAGE_F) ? s + STG_W'(1) : s;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at cycle %0d", cyc);
    endtask

    task automatic check_gap(input string name, input logic [GAP_W-1:0] got,
                             input logic [GAP_W-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input logic [REQ_W-1:0] got,
                              input logic [REQ_W-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // ====================
    // reference model
    // ====================

    // one clock edge, inputs as the DUT samples them
    task automatic step_model();
        logic [GAP_W:0]            sum;
        logic [GAP_W+FACTOR_W-1:0] prod;
        logic                      pop, full, mark, mark_ok, quiet, t_hit, a_hit, one_sat;
        cyc++;
        pop     = (m_ptimer > m_cur) && (m_words.size() != 0);
        full    = (m_words.size() == QDEPTH);
        mark    = ack_valid && ack_ecn;
        mark_ok = mark && (m_timer - m_last_dec > MIN_MARK_GAP);
        quiet   = (m_timer - m_last_mark > ALPHA_IDLE);
        t_hit   = (m_tcnt > TIME_TH);
        a_hit   = (m_acnt > ACK_TH);
        one_sat = (m_tstg >= STAGE_F) != (m_astg >= STAGE_F);
        sum     = {1'b0, m_target} + {1'b0, m_cur};
        prod    = {{FACTOR_W{1'b0}}, m_cur} * {{GAP_W{1'b0}}, FACTOR_TBL[m_fidx]};
        if (!aresetn) begin
            {m_timer, m_last_dec, m_last_mark, m_tcnt, m_acnt, m_ptimer} = '0;
            {m_tstg, m_astg, m_fidx, m_event, m_pop_q, m_out_valid, m_overflow} = '0;
            m_target = TARGET_INIT;
            m_cur    = GAP_INIT;
            m_words.delete();
            m_pop_gaps.delete();
        end else begin
            // output stage sees the read data from the previous pop
            if (m_pop_q) begin
                m_out_data = m_rd_data;
            end
            m_out_valid = m_pop_q;
            m_pop_q     = pop;
            m_ptimer    = pop ? '0 : m_ptimer + GAP_W'(1);
            if (pop) begin
                m_rd_data = m_words.pop_front();
                m_pop_gaps.push_back(m_cur);
            end
            if (req_push && full) begin
                m_overflow = 1'b1;
            end else if (req_push) begin
                m_words.push_back(req_data);
            end
            if (mark) begin
                m_last_mark = m_timer;
            end
            if (mark_ok) begin
                m_last_dec = m_timer;
            end
            m_timer = m_timer + GAP_W'(1);
            if (quiet && m_fidx != FACTOR_MAX) begin
                m_fidx = m_fidx + FIDX_W'(1);
            end else if (mark_ok && m_fidx != '0) begin
                m_fidx = m_fidx - FIDX_W'(1);
            end
            if (m_event && one_sat) begin
                m_target = (m_target > RAI) ? m_target - RAI : GAP_W'(1);
            end else if (mark_ok) begin
                m_target = m_cur;
            end
            if (m_event) begin
                m_cur = sum[GAP_W:1];
            end else if (mark_ok && m_cur <= DEC_LIMIT) begin
                m_cur = GAP_W'(prod >> 7);
            end
            m_tstg  = t_hit ? stage_up(m_tstg) : (mark_ok ? '0 : m_tstg);
            m_astg  = a_hit ? stage_up(m_astg) : (mark_ok ? '0 : m_astg);
            m_tcnt  = (t_hit || mark_ok) ? '0 : m_tcnt + GAP_W'(1);
            m_acnt  = (a_hit || mark_ok) ? '0 : m_acnt + GAP_W'(ack_valid);
            m_event = t_hit || a_hit;
        end
    endtask

    // outputs compared away from the rising edge
    always @(negedge aclk) begin
        if (aresetn) begin
            check_gap("cur_gap", cur_gap, m_cur);
            check_flag("overflow", overflow, m_overflow);
            check_flag("out_valid", out_valid, m_out_valid);
            if (m_out_valid) begin
                check_data("out_data", out_data, m_out_data);
                if (last_ov >= 0 && cyc - last_ov < int'(m_pop_gaps[0]) + 2) begin
                    stop_on_error("two out_valid strobes came closer than the pacing gap");
                end
                m_pop_gaps.delete(0);
                last_ov = cyc;
                delivered++;
            end
        end
    end

    // ====================
    // stimulus
    // ====================

    task automatic run_phase(input int cycles, input logic [2:0] push_lvl,
                             input logic [2:0] ack_lvl, input logic ecn_on);
        logic [63:0] r;
        int          i;
        for (i = 0; i < cycles; i++) begin
            @(posedge aclk);
            step_model();
            take_bits(3, r);
            req_push <= (r[2:0] < push_lvl);
            take_bits(REQ_W, r);
            req_data <= r[REQ_W-1:0];
            take_bits(3, r);
            ack_valid <= (r[2:0] < ack_lvl);
            take_bits(1, r);
            ack_ecn <= ecn_on && r[0];
        end
    endtask

    initial begin
        repeat (WDOG_CYC) @(posedge aclk);
        stop_on_error("watchdog expired before the test sequence finished");
    end

    initial begin
        lfsr      = 32'd49;
        cyc       = 0;
        last_ov   = -1;
        delivered = 0;
        aresetn   <= 1'b0;
        req_push  <= 1'b0;
        req_data  <= '0;
        ack_valid <= 1'b0;
        ack_ecn   <= 1'b0;
        repeat (4) begin
            @(posedge aclk);
            step_model();
        end
        aresetn <= 1'b1;
        @(negedge aclk);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("overflow", overflow, 1'b0);
        check_gap("cur_gap", cur_gap, GAP_INIT);
        // fill past full, quiet acks to bring the gap under the decrease limit,
        // marks, quiet acks, marks after alpha recovery, idle
        run_phase(BURST_CYC, 3'd6, 3'd0, 1'b0);
        run_phase(WARM_CYC, 3'd1, 3'd4, 1'b0);
        run_phase(MARK_CYC, 3'd1, 3'd2, 1'b1);
        run_phase(QUIET_CYC, 3'd1, 3'd4, 1'b0);
        run_phase(REMARK_CYC, 3'd1, 3'd2, 1'b1);
        run_phase(IDLE_CYC, 3'd0, 3'd0, 1'b0);
        while (m_words.size() != 0 || m_pop_q || m_out_valid) begin
            run_phase(1, 3'd0, 3'd0, 1'b0);
        end
        if (!m_overflow) begin
            stop_on_error("no push was ever dropped, the full FIFO case did not run");
        end else if (delivered == 0) begin
            stop_on_error("no request ever reached out_data");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

/* rtl/cc_queue_top.sv */
module cc_queue_top (
    input  logic                           aclk,
    input  logic                           aresetn,
    input  logic                           req_push,
    input  logic [cc_queue_pkg::REQ_W-1:0] req_data,
    input  logic                           ack_valid,
    input  logic                           ack_ecn,
    output logic                           out_valid,
    output logic [cc_queue_pkg::REQ_W-1:0] out_data,
    output logic [cc_queue_pkg::GAP_W-1:0] cur_gap,
    output logic                           overflow
);

    import cc_queue_pkg::*;

    logic             pop;
    logic             empty;
    logic [REQ_W-1:0] rd_data;

    // gap source
    cc_rate_ctrl u_rate (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .ack_valid (ack_valid),
        .ack_ecn   (ack_ecn),
        .cur_gap   (cur_gap)
    );

    req_fifo u_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .push     (req_push),
        .wdata    (req_data),
        .pop      (pop),
        .rd_data  (rd_data),
        .empty    (empty),
        .overflow (overflow)
    );

    req_pacer u_pacer (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .cur_gap   (cur_gap),
        .empty     (empty),
        .rd_data   (rd_data),
        .pop       (pop),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

/* rtl/req_pacer.sv */
module req_pacer (
    input  logic                           aclk,
    input  logic                           aresetn,
    input  logic [cc_queue_pkg::GAP_W-1:0] cur_gap,
    input  logic                           empty,
    input  logic [cc_queue_pkg::REQ_W-1:0] rd_data,
    output logic                           pop,
    output logic                           out_valid,
    output logic [cc_queue_pkg::REQ_W-1:0] out_data
);

    import cc_queue_pkg::*;

    logic [GAP_W-1:0] gap_timer;
    logic             pop_q;

    // ====================
    // send decision
    // ====================

    // gap elapsed and something waiting
    assign pop = (gap_timer > cur_gap) && !empty;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            gap_timer <= '0;
        end else if (pop) begin
            gap_timer <= '0;
        end else begin
            gap_timer <= gap_timer + 1'b1;
        end
    end

    // ====================
    // output stage
    // ====================

    // fifo read data lands one cycle after the pop
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pop_q     <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            pop_q     <= pop;
            out_valid <= pop_q;
        end
    end

    always_ff @(posedge aclk) begin
        if (pop_q) begin
            out_data <= rd_data;
        end
    end

    a_pop_spaced: assert property (@(posedge aclk) disable iff (!aresetn)
        pop |=> !pop);

endmodule

/* rtl/req_fifo.sv */
module req_fifo (
    input  logic                           aclk,
    input  logic                           aresetn,
    input  logic                           push,
    input  logic [cc_queue_pkg::REQ_W-1:0] wdata,
    input  logic                           pop,
    output logic [cc_queue_pkg::REQ_W-1:0] rd_data,
    output logic                           empty,
    output logic                           overflow
);

    import cc_queue_pkg::*;

    logic [REQ_W-1:0]  mem [0:QDEPTH-1];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [QCNT_W-1:0] count;
    logic              do_push;
    logic              do_pop;

    assign empty   = (count == '0);
    assign do_push = push && (count != QDEPTH[QCNT_W-1:0]);
    assign do_pop  = pop && !empty;

    // storage and read register
    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
        if (do_pop) begin
            rd_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
            // dropped push is remembered until reset
            if (push && !do_push) begin
                overflow <= 1'b1;
            end
        end
    end

    a_no_pop_empty: assert property (@(posedge aclk) disable iff (!aresetn)
        !(pop && empty));

endmodule

/* rtl/cc_rate_ctrl.sv */
module cc_rate_ctrl (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          ack_valid,
    input  logic                          ack_ecn,
    output logic [cc_queue_pkg::GAP_W-1:0] cur_gap
);

    import cc_queue_pkg::*;

    logic [GAP_W-1:0] timer;
    logic [GAP_W-1:0] target;
    logic [GAP_W-1:0] current;
    logic [GAP_W-1:0] last_dec;
    logic [GAP_W-1:0] last_mark;
    logic [GAP_W-1:0] time_cnt;
    logic [GAP_W-1:0] ack_cnt;
    logic [STG_W-1:0] time_stage;
    logic [STG_W-1:0] ack_stage;
    logic [FIDX_W-1:0] fidx;
    logic             inc_event;

    logic [GAP_W+FACTOR_W-1:0] scaled;
    logic [GAP_W:0]            mean_sum;
    logic [GAP_W-1:0]          since_dec;
    logic [GAP_W-1:0]          since_mark;
    logic                      sat_time;
    logic                      sat_ack;

    // ====================
    // datapath helpers
    // ====================

    assign scaled     = current * FACTOR_TBL[fidx];
    assign mean_sum   = target + current;
    assign since_dec  = timer - last_dec;
    assign since_mark = timer - last_mark;
    assign sat_time   = (time_stage >= STAGE_F);
    assign sat_ack    = (ack_stage >= STAGE_F);

    assign cur_gap = current;

    // ====================
    // rate state
    // ====================

    // later assignments in this block win over earlier ones
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            timer      <= '0;
            target     <= TARGET_INIT;
            current    <= GAP_INIT;
            last_dec   <= '0;
            last_mark  <= '0;
            time_cnt   <= '0;
            ack_cnt    <= '0;
            time_stage <= '0;
            ack_stage  <= '0;
            fidx       <= '0;
            inc_event  <= 1'b0;
        end else begin
            timer     <= timer + 1'b1;
            time_cnt  <= time_cnt + 1'b1;
            inc_event <= 1'b0;

            if (ack_valid) begin
                ack_cnt <= ack_cnt + 1'b1;
                if (ack_ecn) begin
                    // marks too close to the last decrease only refresh the mark time
                    if (since_dec > MIN_MARK_GAP) begin
                        target <= current;
                        if (current <= DEC_LIMIT) begin
                            current <= scaled[GAP_W+6:7];
                        end
                        if (fidx != '0) begin
                            fidx <= fidx - 1'b1;
                        end
                        last_dec   <= timer;
                        time_cnt   <= '0;
                        ack_cnt    <= '0;
                        time_stage <= '0;
                        ack_stage  <= '0;
                    end
                    last_mark <= timer;
                end
            end

            // long quiet period, soften the next decrease
            if (since_mark > ALPHA_IDLE && fidx != FACTOR_MAX) begin
                fidx <= fidx + 1'b1;
            end

            if (time_cnt > TIME_TH) begin
                time_cnt   <= '0;
                inc_event  <= 1'b1;
                time_stage <= (time_stage < STAGE_F) ? time_stage + 1'b1 : STAGE_F;
            end

            if (ack_cnt > ACK_TH) begin
                ack_cnt   <= '0;
                inc_event <= 1'b1;
                ack_stage <= (ack_stage < STAGE_F) ? ack_stage + 1'b1 : STAGE_F;
            end

            // fast recovery and hyper increase only pull current toward target
            if (inc_event) begin
                current <= mean_sum[GAP_W:1];
                if (sat_time != sat_ack) begin
                    // additive step, floored at 1 near zero
                    if (target <= RAI) begin
                        target <= 32'd1;
                    end else begin
                        target <= target - RAI;
                    end
                end
            end
        end
    end

    a_fidx_range: assert property (@(posedge aclk) disable iff (!aresetn)
        fidx <= FACTOR_MAX);

endmodule

/* rtl/cc_queue_pkg.sv */
package cc_queue_pkg;

    // ====================
    // request queue
    // ====================

    // opcode bit, 32-bit address and 15-bit length, moved as one word
    localparam int REQ_W = 48;

    localparam int QDEPTH = 20;
    localparam int PTR_W  = $clog2(QDEPTH);
    localparam int QCNT_W = $clog2(QDEPTH) + 1;

    // ====================
    // rate control
    // ====================

    // gaps and timers are in clock cycles
    localparam int GAP_W = 32;

    localparam logic [GAP_W-1:0] GAP_INIT     = 32'd8192;
    localparam logic [GAP_W-1:0] TARGET_INIT  = 32'd128;
    localparam logic [GAP_W-1:0] MIN_MARK_GAP = 32'd200;
    localparam logic [GAP_W-1:0] ALPHA_IDLE   = 32'd600;
    localparam logic [GAP_W-1:0] DEC_LIMIT    = 32'd4096;

    // increase thresholds and additive step
    localparam logic [GAP_W-1:0] TIME_TH = 32'd150;
    localparam logic [GAP_W-1:0] ACK_TH  = 32'd10;
    localparam logic [GAP_W-1:0] RAI     = 32'd60;

    // stage counters saturate here
    localparam int               STG_W   = 3;
    localparam logic [STG_W-1:0] STAGE_F = 3'd5;

    // decrease factors in 1/128 units, index 0 is the harshest
    localparam int                FIDX_W     = 5;
    localparam int                FACTOR_W   = 9;
    localparam logic [FIDX_W-1:0] FACTOR_MAX = 5'd28;

    localparam logic [FACTOR_W-1:0] FACTOR_TBL [0:FACTOR_MAX] = '{
        9'd256, 9'd241, 9'd228, 9'd218, 9'd209, 9'd201, 9'd194, 9'd188,
        9'd182, 9'd178, 9'd173, 9'd170, 9'd166, 9'd163, 9'd161, 9'd158,
        9'd156, 9'd154, 9'd152, 9'd150, 9'd148, 9'd147, 9'd146, 9'd144,
        9'd143, 9'd142, 9'd141, 9'd140, 9'd139
    };

endpackage
